// ==== Bender.yml ====
package:
  name: decode_top

export_include_dirs:
  - .

sources:
  - decode_pkg.sv
  - fetch_buffer.sv
  - decode_lane.sv
  - issue_queue.sv
  - decode_top.sv
  - target: test
    files:
      - tb_decode_top.sv

// ==== decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Words per fetch packet, and the number of decode lanes.
`define DECODE_LANES 2

// Packets held in the fetch buffer, and the fetch credits of the source.
`define FETCH_DEPTH 4

// Groups held in the issue queue, and the backend and slot credits.
`define ISSUE_DEPTH 4

`define XLEN 32

`endif

// ==== decode_lane.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_lane import decode_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             flush,
  input  logic             lane_valid,
  input  logic [`XLEN-1:0] lane_pc,
  input  logic [31:0]      lane_word,
  output logic             uop_valid,
  output logic [`XLEN-1:0] uop_pc,
  output unit_e            uop_unit,
  output logic [2:0]       uop_funct3,
  output logic [4:0]       uop_rd,
  output logic             uop_rd_en,
  output logic [4:0]       uop_rs1,
  output logic             uop_rs1_en,
  output logic [4:0]       uop_rs2,
  output logic             uop_rs2_en,
  output logic [`XLEN-1:0] uop_imm,
  output logic             uop_illegal
);
  instr_word_u      word;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm;
  logic             funct7_ok;
  unit_e            unit;
  logic             legal;
  logic             wr;
  logic             rd1;
  logic             rd2;
  logic             rd_en_d;
  logic             rs1_en_d;
  logic             rs2_en_d;

  assign word = lane_word;

  assign imm_i = {{(`XLEN-12){lane_word[31]}}, lane_word[31:20]};
  assign imm_s = {{(`XLEN-12){word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
  assign imm_b = {{(`XLEN-13){lane_word[31]}}, lane_word[31], lane_word[7],
                  lane_word[30:25], lane_word[11:8], 1'b0};
  assign imm_u = {lane_word[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){lane_word[31]}}, lane_word[31], lane_word[19:12],
                  lane_word[20], lane_word[30:21], 1'b0};

  // Only sub, sra and srai may set funct7 bit 5.
  assign funct7_ok = (word.r.funct7 == 7'b0000000) ||
                     (word.r.funct7 == 7'b0100000 &&
                      (word.r.funct3 == 3'd0 || word.r.funct3 == 3'd5));

  always_comb begin
    unit  = unit_illegal;
    legal = 1'b1;
    wr    = 1'b0;
    rd1   = 1'b0;
    rd2   = 1'b0;
    imm   = '0;
    case (word.r.opcode)
      opc_lui: begin
        unit = unit_lui;
        wr   = 1'b1;
        imm  = imm_u;
      end
      opc_auipc: begin
        unit = unit_auipc;
        wr   = 1'b1;
        imm  = imm_u;
      end
      opc_jal: begin
        unit = unit_jal;
        wr   = 1'b1;
        imm  = imm_j;
      end
      opc_jalr: begin
        unit  = unit_jalr;
        legal = (word.r.funct3 == 3'd0);
        wr    = 1'b1;
        rd1   = 1'b1;
        imm   = imm_i;
      end
      opc_branch: begin
        unit  = unit_branch;
        legal = (word.r.funct3 != 3'd2) && (word.r.funct3 != 3'd3);
        rd1   = 1'b1;
        rd2   = 1'b1;
        imm   = imm_b;
      end
      opc_load: begin
        unit  = unit_load;
        legal = (word.r.funct3 != 3'd3) && (word.r.funct3 < 3'd6);
        wr    = 1'b1;
        rd1   = 1'b1;
        imm   = imm_i;
      end
      opc_store: begin
        unit  = unit_store;
        legal = (word.r.funct3 < 3'd3);
        rd1   = 1'b1;
        rd2   = 1'b1;
        imm   = imm_s;
      end
      opc_op_imm: begin
        unit  = unit_alu;
        legal = (word.r.funct3 != 3'd1 && word.r.funct3 != 3'd5) || funct7_ok;
        wr    = 1'b1;
        rd1   = 1'b1;
        imm   = imm_i;
      end
      opc_op: begin
        unit  = unit_alu;
        legal = funct7_ok;
        wr    = 1'b1;
        rd1   = 1'b1;
        rd2   = 1'b1;
      end
      opc_misc_mem: begin
        unit = unit_fence; // Fence fields are not checked.
      end
      opc_system: begin
        if (lane_word == 32'h0000_0073) begin
          unit = unit_ecall;
        end else if (lane_word == 32'h0010_0073) begin
          unit = unit_ebreak;
        end else begin
          legal = 1'b0;
        end
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  assign rd_en_d  = legal && wr && (word.r.rd != 5'd0); // Writes to x0 are dropped.
  assign rs1_en_d = legal && rd1;
  assign rs2_en_d = legal && rd2;

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      uop_valid <= 1'b0;
    end else begin
      uop_valid <= lane_valid;
    end
  end

  // Legal words keep their raw funct3 bits, whatever the format.
  always_ff @(posedge clock) begin
    if (lane_valid) begin
      uop_pc      <= lane_pc;
      uop_unit    <= legal ? unit : unit_illegal;
      uop_funct3  <= legal ? word.r.funct3 : 3'd0;
      uop_rd      <= rd_en_d ? word.r.rd : 5'd0;
      uop_rd_en   <= rd_en_d;
      uop_rs1     <= rs1_en_d ? word.r.rs1 : 5'd0;
      uop_rs1_en  <= rs1_en_d;
      uop_rs2     <= rs2_en_d ? word.r.rs2 : 5'd0;
      uop_rs2_en  <= rs2_en_d;
      uop_imm     <= legal ? imm : '0;
      uop_illegal <= !legal;
    end
  end

  // An exception micro-op reaches the backend with no register traffic.
  a_illegal_quiet: assert property (@(posedge clock) disable iff (!reset)
    uop_valid && uop_illegal |-> !(uop_rd_en || uop_rs1_en || uop_rs2_en));

endmodule

// ==== decode_pkg.sv ====
package decode_pkg;

  typedef enum logic [6:0] {
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_branch   = 7'b1100011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_misc_mem = 7'b0001111,
    opc_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    unit_alu     = 4'd0,
    unit_lui     = 4'd1,
    unit_auipc   = 4'd2,
    unit_jal     = 4'd3,
    unit_jalr    = 4'd4,
    unit_branch  = 4'd5,
    unit_load    = 4'd6,
    unit_store   = 4'd7,
    unit_fence   = 4'd8,
    unit_ecall   = 4'd9,
    unit_ebreak  = 4'd10,
    unit_illegal = 4'd15
  } unit_e;

  // One instruction word seen in R-type or in S-type layout.
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
  } instr_word_u;

endpackage

// ==== decode_top.f ====
+incdir+.
decode_pkg.sv
fetch_buffer.sv
decode_lane.sv
issue_queue.sv
decode_top.sv
tb_decode_top.sv

// ==== decode_top.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_top import decode_pkg::*; (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                flush,
  input  logic                                fetch_valid,
  input  logic [`XLEN-1:0]                    fetch_pc,
  input  logic [`DECODE_LANES-1:0][31:0]      fetch_data,
  output logic                                fetch_credit,
  input  logic                                issue_credit,
  output logic                                issue_valid,
  output logic [`DECODE_LANES-1:0][`XLEN-1:0] issue_pc,
  output unit_e [`DECODE_LANES-1:0]           issue_unit,
  output logic [`DECODE_LANES-1:0][2:0]       issue_funct3,
  output logic [`DECODE_LANES-1:0][4:0]       issue_rd,
  output logic [`DECODE_LANES-1:0]            issue_rd_en,
  output logic [`DECODE_LANES-1:0][4:0]       issue_rs1,
  output logic [`DECODE_LANES-1:0]            issue_rs1_en,
  output logic [`DECODE_LANES-1:0][4:0]       issue_rs2,
  output logic [`DECODE_LANES-1:0]            issue_rs2_en,
  output logic [`DECODE_LANES-1:0][`XLEN-1:0] issue_imm,
  output logic [`DECODE_LANES-1:0]            issue_illegal
);
  logic                                slot_credit;
  logic                                lane_valid;
  logic [`DECODE_LANES-1:0][`XLEN-1:0] lane_pc;
  logic [`DECODE_LANES-1:0][31:0]      lane_word;
  logic [`DECODE_LANES-1:0]            uop_valid;
  logic [`DECODE_LANES-1:0][`XLEN-1:0] uop_pc;
  unit_e [`DECODE_LANES-1:0]           uop_unit;
  logic [`DECODE_LANES-1:0][2:0]       uop_funct3;
  logic [`DECODE_LANES-1:0][4:0]       uop_rd;
  logic [`DECODE_LANES-1:0]            uop_rd_en;
  logic [`DECODE_LANES-1:0][4:0]       uop_rs1;
  logic [`DECODE_LANES-1:0]            uop_rs1_en;
  logic [`DECODE_LANES-1:0][4:0]       uop_rs2;
  logic [`DECODE_LANES-1:0]            uop_rs2_en;
  logic [`DECODE_LANES-1:0][`XLEN-1:0] uop_imm;
  logic [`DECODE_LANES-1:0]            uop_illegal;

  fetch_buffer buffer0 (.*);

  for (genvar k = 0; k < `DECODE_LANES; k++) begin : g_lane
    decode_lane lane0 (
      .clock       (clock),
      .reset       (reset),
      .flush       (flush),
      .lane_valid  (lane_valid),
      .lane_pc     (lane_pc[k]),
      .lane_word   (lane_word[k]),
      .uop_valid   (uop_valid[k]),
      .uop_pc      (uop_pc[k]),
      .uop_unit    (uop_unit[k]),
      .uop_funct3  (uop_funct3[k]),
      .uop_rd      (uop_rd[k]),
      .uop_rd_en   (uop_rd_en[k]),
      .uop_rs1     (uop_rs1[k]),
      .uop_rs1_en  (uop_rs1_en[k]),
      .uop_rs2     (uop_rs2[k]),
      .uop_rs2_en  (uop_rs2_en[k]),
      .uop_imm     (uop_imm[k]),
      .uop_illegal (uop_illegal[k])
    );
  end

  issue_queue queue0 (.*);

endmodule

// ==== fetch_buffer.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module fetch_buffer (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                flush,
  input  logic                                fetch_valid,
  input  logic [`XLEN-1:0]                    fetch_pc,
  input  logic [`DECODE_LANES-1:0][31:0]      fetch_data,
  output logic                                fetch_credit,
  input  logic                                slot_credit,
  output logic                                lane_valid,
  output logic [`DECODE_LANES-1:0][`XLEN-1:0] lane_pc,
  output logic [`DECODE_LANES-1:0][31:0]      lane_word
);
  localparam int PTR_W = (`FETCH_DEPTH > 1) ? $clog2(`FETCH_DEPTH) : 1;
  localparam int CNT_W = $clog2(`FETCH_DEPTH + 1);
  localparam int SLOT_W = $clog2(`ISSUE_DEPTH + 1);

  logic [`XLEN-1:0]               pc_mem [`FETCH_DEPTH];
  logic [`DECODE_LANES-1:0][31:0] data_mem [`FETCH_DEPTH];
  logic [PTR_W-1:0]               wr_ptr;
  logic [PTR_W-1:0]               rd_ptr;
  logic [CNT_W-1:0]               count;
  logic [SLOT_W-1:0]              slots;
  logic                           full;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`FETCH_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (count == CNT_W'(`FETCH_DEPTH));

  // The head goes out whenever the issue queue has room reserved for it.
  assign lane_valid = (count != '0) && (slots != '0);

  always_comb begin
    for (int k = 0; k < `DECODE_LANES; k++) begin
      lane_pc[k] = pc_mem[rd_ptr] + `XLEN'(4 * k);
    end
  end

  assign lane_word = data_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      slots        <= SLOT_W'(`ISSUE_DEPTH);
      fetch_credit <= 1'b0;
    end else begin
      if (fetch_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (lane_valid) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count        <= count + CNT_W'(fetch_valid) - CNT_W'(lane_valid);
      slots        <= slots + SLOT_W'(slot_credit) - SLOT_W'(lane_valid);
      fetch_credit <= lane_valid; // The freed entry goes back to the source.
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      pc_mem[wr_ptr]   <= fetch_pc;
      data_mem[wr_ptr] <= fetch_data;
    end
  end

  // A full buffer means the source has no credit left, so it must not send.
  a_fetch_credit: assert property (@(posedge clock) disable iff (!reset || flush)
    full |-> !fetch_valid);

endmodule

// ==== issue_queue.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module issue_queue import decode_pkg::*; (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                flush,
  input  logic [`DECODE_LANES-1:0]            uop_valid,
  input  logic [`DECODE_LANES-1:0][`XLEN-1:0] uop_pc,
  input  unit_e [`DECODE_LANES-1:0]           uop_unit,
  input  logic [`DECODE_LANES-1:0][2:0]       uop_funct3,
  input  logic [`DECODE_LANES-1:0][4:0]       uop_rd,
  input  logic [`DECODE_LANES-1:0]            uop_rd_en,
  input  logic [`DECODE_LANES-1:0][4:0]       uop_rs1,
  input  logic [`DECODE_LANES-1:0]            uop_rs1_en,
  input  logic [`DECODE_LANES-1:0][4:0]       uop_rs2,
  input  logic [`DECODE_LANES-1:0]            uop_rs2_en,
  input  logic [`DECODE_LANES-1:0][`XLEN-1:0] uop_imm,
  input  logic [`DECODE_LANES-1:0]            uop_illegal,
  output logic                                slot_credit,
  input  logic                                issue_credit,
  output logic                                issue_valid,
  output logic [`DECODE_LANES-1:0][`XLEN-1:0] issue_pc,
  output unit_e [`DECODE_LANES-1:0]           issue_unit,
  output logic [`DECODE_LANES-1:0][2:0]       issue_funct3,
  output logic [`DECODE_LANES-1:0][4:0]       issue_rd,
  output logic [`DECODE_LANES-1:0]            issue_rd_en,
  output logic [`DECODE_LANES-1:0][4:0]       issue_rs1,
  output logic [`DECODE_LANES-1:0]            issue_rs1_en,
  output logic [`DECODE_LANES-1:0][4:0]       issue_rs2,
  output logic [`DECODE_LANES-1:0]            issue_rs2_en,
  output logic [`DECODE_LANES-1:0][`XLEN-1:0] issue_imm,
  output logic [`DECODE_LANES-1:0]            issue_illegal
);
  localparam int PTR_W = (`ISSUE_DEPTH > 1) ? $clog2(`ISSUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(`ISSUE_DEPTH + 1);

  logic [`DECODE_LANES-1:0][`XLEN-1:0] mem_pc [`ISSUE_DEPTH];
  unit_e [`DECODE_LANES-1:0]           mem_unit [`ISSUE_DEPTH];
  logic [`DECODE_LANES-1:0][2:0]       mem_funct3 [`ISSUE_DEPTH];
  logic [`DECODE_LANES-1:0][4:0]       mem_rd [`ISSUE_DEPTH];
  logic [`DECODE_LANES-1:0]            mem_rd_en [`ISSUE_DEPTH];
  logic [`DECODE_LANES-1:0][4:0]       mem_rs1 [`ISSUE_DEPTH];
  logic [`DECODE_LANES-1:0]            mem_rs1_en [`ISSUE_DEPTH];
  logic [`DECODE_LANES-1:0][4:0]       mem_rs2 [`ISSUE_DEPTH];
  logic [`DECODE_LANES-1:0]            mem_rs2_en [`ISSUE_DEPTH];
  logic [`DECODE_LANES-1:0][`XLEN-1:0] mem_imm [`ISSUE_DEPTH];
  logic [`DECODE_LANES-1:0]            mem_illegal [`ISSUE_DEPTH];
  logic [PTR_W-1:0]                    wr_ptr;
  logic [PTR_W-1:0]                    rd_ptr;
  logic [CNT_W-1:0]                    count;
  logic [CNT_W-1:0]                    credits;
  logic                                push;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`ISSUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = |uop_valid;

  // Nothing leaves while a flush is discarding the queue.
  assign issue_valid = (count != '0) && (credits != '0) && !flush;
  assign slot_credit = issue_valid; // Each issued group frees one slot upstream.

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CNT_W'(`ISSUE_DEPTH);
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (issue_valid) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count   <= count + CNT_W'(push) - CNT_W'(issue_valid);
      credits <= credits + CNT_W'(issue_credit) - CNT_W'(issue_valid);
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem_pc[wr_ptr]      <= uop_pc;
      mem_unit[wr_ptr]    <= uop_unit;
      mem_funct3[wr_ptr]  <= uop_funct3;
      mem_rd[wr_ptr]      <= uop_rd;
      mem_rd_en[wr_ptr]   <= uop_rd_en;
      mem_rs1[wr_ptr]     <= uop_rs1;
      mem_rs1_en[wr_ptr]  <= uop_rs1_en;
      mem_rs2[wr_ptr]     <= uop_rs2;
      mem_rs2_en[wr_ptr]  <= uop_rs2_en;
      mem_imm[wr_ptr]     <= uop_imm;
      mem_illegal[wr_ptr] <= uop_illegal;
    end
  end

  assign issue_pc      = mem_pc[rd_ptr];
  assign issue_unit    = mem_unit[rd_ptr];
  assign issue_funct3  = mem_funct3[rd_ptr];
  assign issue_rd      = mem_rd[rd_ptr];
  assign issue_rd_en   = mem_rd_en[rd_ptr];
  assign issue_rs1     = mem_rs1[rd_ptr];
  assign issue_rs1_en  = mem_rs1_en[rd_ptr];
  assign issue_rs2     = mem_rs2[rd_ptr];
  assign issue_rs2_en  = mem_rs2_en[rd_ptr];
  assign issue_imm     = mem_imm[rd_ptr];
  assign issue_illegal = mem_illegal[rd_ptr];

  // Slot credits upstream reserve room for every group in flight.
  a_no_overflow: assert property (@(posedge clock) disable iff (!reset || flush)
    push |-> count != CNT_W'(`ISSUE_DEPTH));

  // Spending the last backend credit holds issue until one comes back.
  a_credit_limit: assert property (@(posedge clock) disable iff (!reset || flush)
    issue_valid && credits == CNT_W'(1) && !issue_credit |=> !issue_valid);

endmodule

// ==== tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Packets accepted by the DUT, oldest first. Each is decoded when its group issues.
logic [`XLEN-1:0]               exp_pc_q [$];
logic [`DECODE_LANES-1:0][31:0] exp_data_q [$];

logic [3:0]  exp_unit;
logic [2:0]  exp_funct3;
logic [4:0]  exp_rd;
logic        exp_rd_en;
logic [4:0]  exp_rs1;
logic        exp_rs1_en;
logic [4:0]  exp_rs2;
logic        exp_rs2_en;
logic [31:0] exp_imm;
logic        exp_illegal;

// Reference RV32I decode of one word into the expected micro-op fields.
task automatic decode_word(input logic [31:0] w);
  logic [2:0]  f3;
  logic        f7_ok;
  logic        ok;
  logic        wr;
  logic        r1;
  logic        r2;
  logic [31:0] imm;
  logic [3:0]  unit;
  f3    = w[14:12];
  f7_ok = (w[31:25] == 7'h00) || (w[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
  ok    = 1'b1;
  wr    = 1'b0;
  r1    = 1'b0;
  r2    = 1'b0;
  imm   = '0;
  unit  = unit_illegal;
  case (w[6:0])
    7'h37: begin
      unit = unit_lui;
      wr   = 1'b1;
      imm  = {w[31:12], 12'b0};
    end
    7'h17: begin
      unit = unit_auipc;
      wr   = 1'b1;
      imm  = {w[31:12], 12'b0};
    end
    7'h6f: begin
      unit = unit_jal;
      wr   = 1'b1;
      imm  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    end
    7'h67: begin
      unit = unit_jalr;
      ok   = (f3 == 3'd0);
      wr   = 1'b1;
      r1   = 1'b1;
      imm  = {{20{w[31]}}, w[31:20]};
    end
    7'h63: begin
      unit = unit_branch;
      ok   = (f3 != 3'd2) && (f3 != 3'd3);
      r1   = 1'b1;
      r2   = 1'b1;
      imm  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    end
    7'h03: begin
      unit = unit_load;
      ok   = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
      wr   = 1'b1;
      r1   = 1'b1;
      imm  = {{20{w[31]}}, w[31:20]};
    end
    7'h23: begin
      unit = unit_store;
      ok   = (f3 <= 3'd2);
      r1   = 1'b1;
      r2   = 1'b1;
      imm  = {{20{w[31]}}, w[31:25], w[11:7]};
    end
    7'h13: begin
      unit = unit_alu;
      ok   = (f3 == 3'd1 || f3 == 3'd5) ? f7_ok : 1'b1; // Shifts only.
      wr   = 1'b1;
      r1   = 1'b1;
      imm  = {{20{w[31]}}, w[31:20]};
    end
    7'h33: begin
      unit = unit_alu;
      ok   = f7_ok;
      wr   = 1'b1;
      r1   = 1'b1;
      r2   = 1'b1;
    end
    7'h0f: unit = unit_fence;
    7'h73: begin
      if (w == 32'h0000_0073) unit = unit_ecall;
      else if (w == 32'h0010_0073) unit = unit_ebreak;
      else ok = 1'b0;
    end
    default: ok = 1'b0;
  endcase
  exp_illegal = !ok;
  exp_unit    = ok ? unit : unit_illegal;
  exp_funct3  = ok ? f3 : 3'd0;
  exp_rd_en   = ok && wr && (w[11:7] != 5'd0);
  exp_rd      = exp_rd_en ? w[11:7] : 5'd0;
  exp_rs1_en  = ok && r1;
  exp_rs1     = exp_rs1_en ? w[19:15] : 5'd0;
  exp_rs2_en  = ok && r2;
  exp_rs2     = exp_rs2_en ? w[24:20] : 5'd0;
  exp_imm     = ok ? imm : '0;
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    fail_run($sformatf("Wrong value for %s", name));
  end
endtask

// Pops the oldest accepted packet and checks the issued group against it.
task automatic compare_group();
  logic [`XLEN-1:0]               pc;
  logic [`DECODE_LANES-1:0][31:0] data;
  string                          tag;
  if (exp_pc_q.size() == 0) begin
    fail_run("A group issued while no accepted packet was waiting");
  end else begin
    pc   = exp_pc_q.pop_front();
    data = exp_data_q.pop_front();
    for (int k = 0; k < `DECODE_LANES; k++) begin
      decode_word(data[k]);
      tag = $sformatf("group %0d lane %0d", issued, k);
      check_value({tag, " pc"}, pc + 4 * k, issue_pc[k]);
      check_value({tag, " unit"}, exp_unit, issue_unit[k]);
      check_value({tag, " funct3"}, exp_funct3, issue_funct3[k]);
      check_value({tag, " rd"}, exp_rd, issue_rd[k]);
      check_value({tag, " rd_en"}, exp_rd_en, issue_rd_en[k]);
      check_value({tag, " rs1"}, exp_rs1, issue_rs1[k]);
      check_value({tag, " rs1_en"}, exp_rs1_en, issue_rs1_en[k]);
      check_value({tag, " rs2"}, exp_rs2, issue_rs2[k]);
      check_value({tag, " rs2_en"}, exp_rs2_en, issue_rs2_en[k]);
      check_value({tag, " imm"}, exp_imm, issue_imm[k]);
      check_value({tag, " illegal"}, exp_illegal, issue_illegal[k]);
    end
  end
endtask

`endif

// ==== tb_decode_top.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module tb_decode_top import decode_pkg::*; ();
  logic                                clock;
  logic                                reset;
  logic                                flush;
  logic                                fetch_valid;
  logic [`XLEN-1:0]                    fetch_pc;
  logic [`DECODE_LANES-1:0][31:0]      fetch_data;
  logic                                fetch_credit;
  logic                                issue_credit;
  logic                                issue_valid;
  logic [`DECODE_LANES-1:0][`XLEN-1:0] issue_pc;
  unit_e [`DECODE_LANES-1:0]           issue_unit;
  logic [`DECODE_LANES-1:0][2:0]       issue_funct3;
  logic [`DECODE_LANES-1:0][4:0]       issue_rd;
  logic [`DECODE_LANES-1:0]            issue_rd_en;
  logic [`DECODE_LANES-1:0][4:0]       issue_rs1;
  logic [`DECODE_LANES-1:0]            issue_rs1_en;
  logic [`DECODE_LANES-1:0][4:0]       issue_rs2;
  logic [`DECODE_LANES-1:0]            issue_rs2_en;
  logic [`DECODE_LANES-1:0][`XLEN-1:0] issue_imm;
  logic [`DECODE_LANES-1:0]            issue_illegal;

  integer seed;
  int     src_credits; // Fetch credits held by the source.
  int     dut_credits; // Issue credits held by the DUT.
  int     owed;
  int     outstanding;
  int     issued;
  int     burst_left;
  bit     holding;
  int     base;
  logic [6:0] legal_opcodes [11] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03,
                                     7'h23, 7'h13, 7'h33, 7'h0f, 7'h73};

  `include "tb_decode_model.svh"

  decode_top dut0 (.*);

  initial clock = 1'b0;
  always #50 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "%s", why);
  endtask

  // About half the words carry a real opcode, the rest are raw random bits.
  function automatic logic [31:0] gen_word();
    logic [31:0] r;
    logic [31:0] w;
    int          sel;
    r   = $random(seed);
    sel = $unsigned($random(seed)) % 24;
    if (sel < 11) begin
      w = {r[31:7], legal_opcodes[sel]};
      if (r[0]) w[31:25] = r[1] ? 7'h20 : 7'h00;
      if (r[4:2] == 3'd0) w[11:7] = 5'd0;
    end else if (sel == 11) begin
      w = 32'h0000_0073;
    end else if (sel == 12) begin
      w = 32'h0010_0073;
    end else begin
      w = r;
    end
    return w;
  endfunction

  task automatic drive_cycles(input int cycles, input bit send, input bit hold_all);
    int r;
    repeat (cycles) begin
      @(negedge clock);
      r = $random(seed);
      if (burst_left == 0) begin
        holding    = (r[1:0] == 2'b00); // Backend stalls in random bursts.
        burst_left = 1 + r[7:2];
      end
      burst_left  = burst_left - 1;
      flush       = 1'b0;
      fetch_valid = send && (src_credits > 0) && r[8];
      fetch_pc    = $random(seed) & ~32'h3;
      for (int k = 0; k < `DECODE_LANES; k++) begin
        fetch_data[k] = gen_word();
      end
      issue_credit = !hold_all && !holding && (owed > 0);
    end
  endtask

  task automatic flush_pipeline();
    @(negedge clock);
    flush        = 1'b1;
    fetch_valid  = 1'b0;
    issue_credit = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_pc_q.size() != 0 || owed != 0) begin
      if (waited == 4000) begin
        fail_run("Timeout while draining the decode pipeline");
      end else begin
        drive_cycles(1, 1'b0, 1'b0);
        waited = waited + 1;
      end
    end
    drive_cycles(2, 1'b0, 1'b0);
    check_value("source credits after drain", `FETCH_DEPTH, src_credits);
  endtask

  task automatic wait_for_issues(input int target);
    int waited;
    waited = 0;
    while (issued < target) begin
      if (waited == 200) begin
        fail_run("Timeout waiting for groups to issue after the flush");
      end else begin
        drive_cycles(1, 1'b1, 1'b1);
        waited = waited + 1;
      end
    end
  endtask

  // Source and backend model. Outputs are stable here since inputs move on the falling edge.
  always @(posedge clock) begin
    if (reset && flush) begin
      exp_pc_q.delete();
      exp_data_q.delete();
      src_credits = `FETCH_DEPTH;
      dut_credits = `ISSUE_DEPTH;
      owed        = 0;
      outstanding = 0;
    end else if (reset) begin
      if (issue_valid) begin
        if (dut_credits == 0) begin
          fail_run("issue_valid was raised with no issue credits left");
        end else begin
          compare_group();
          dut_credits = dut_credits - 1;
          owed        = owed + 1;
          issued      = issued + 1;
        end
      end
      if (issue_credit) begin
        dut_credits = dut_credits + 1;
        owed        = owed - 1;
      end
      if (fetch_credit) begin
        if (outstanding == 0) begin
          fail_run("fetch_credit returned a credit for a packet that was never accepted");
        end else begin
          outstanding = outstanding - 1;
          src_credits = src_credits + 1;
        end
      end
      if (fetch_valid) begin
        exp_pc_q.push_back(fetch_pc);
        exp_data_q.push_back(fetch_data);
        src_credits = src_credits - 1;
        outstanding = outstanding + 1;
      end
    end
  end

  initial begin
    seed         = 32'hf611ecab;
    reset        = 1'b0;
    flush        = 1'b0;
    fetch_valid  = 1'b0;
    fetch_pc     = '0;
    fetch_data   = '0;
    issue_credit = 1'b0;
    src_credits  = `FETCH_DEPTH;
    dut_credits  = `ISSUE_DEPTH;
    owed         = 0;
    outstanding  = 0;
    issued       = 0;
    burst_left   = 0;
    holding      = 1'b0;
    repeat (16) begin
      @(negedge clock);
      check_value("issue_valid during reset", 0, issue_valid);
      check_value("fetch_credit during reset", 0, fetch_credit);
    end
    reset = 1'b1;
    @(negedge clock);
    check_value("issue_valid after reset", 0, issue_valid);
    check_value("fetch_credit after reset", 0, fetch_credit);

    drive_cycles(3000, 1'b1, 1'b0);
    drain();

    // Stall the backend so work piles up everywhere, then throw it away.
    drive_cycles(40, 1'b1, 1'b1);
    flush_pipeline();
    base = issued;
    wait_for_issues(base + `ISSUE_DEPTH);
    drive_cycles(20, 1'b1, 1'b1);
    drain();

    drive_cycles(1000, 1'b1, 1'b0);
    drain();

    $display("Simulation PASSED");
    $finish;
  end

endmodule
